//--- include/id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// Datapath and register file widths
`define XLEN        32
`define REG_ADDR_W  5

// Exception vector layout
// IPE, INE, break, syscall, 4 front-end bits, interrupt
`define EXCP_NUM_W  9
`define FE_EXCP_W   4

// Privilege level of user mode
`define PLV_USER    2'd3

// 3R opcodes, instr[31:15]
`define OP3R_ADDW       17'h00020
`define OP3R_SUBW       17'h00022
`define OP3R_AND        17'h00029
`define OP3R_OR         17'h0002a
`define OP3R_BREAK      17'h00054
`define OP3R_SYSCALL    17'h00056

// 2RI12 opcodes, instr[31:22]
`define OP12_ADDIW      10'h00a
`define OP12_LDW        10'h0a2
`define OP12_STW        10'h0a6

// 1RI20 opcodes, instr[31:25]
`define OP20_LU12IW     7'h0a
`define OP20_PCADDU12I  7'h0e

// I26 opcodes, instr[31:26]
`define OP26_B          6'h14
`define OP26_BL         6'h15

// CSR access group, instr[31:24]
`define OPCSR           8'h04

`endif

//--- logic/core_types_pkg.sv
`include "id_macros.svh"

`default_nettype none

package core_types_pkg;

    // NOP must stay zero so decoder results can be ORed
    typedef enum logic [3:0] {
        OP_NOP       = 4'd0,
        OP_ADD       = 4'd1,
        OP_SUB       = 4'd2,
        OP_AND       = 4'd3,
        OP_OR        = 4'd4,
        OP_LUI       = 4'd5,
        OP_PCADDU12I = 4'd6,
        OP_LD_W      = 4'd7,
        OP_ST_W      = 4'd8,
        OP_B         = 4'd9,
        OP_BL        = 4'd10,
        OP_CSRRD     = 4'd11,
        OP_CSRWR     = 4'd12,
        OP_CSRXCHG   = 4'd13
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP    = 3'd0,
        SEL_LOGIC  = 3'd1,
        SEL_ARITH  = 3'd2,
        SEL_MOVE   = 3'd3,
        SEL_BRANCH = 3'd4,
        SEL_MEM    = 3'd5,
        SEL_CSR    = 3'd6
    } alusel_e;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      instr;
        logic                  excp;
        logic [`FE_EXCP_W-1:0] excp_code;
    } fetch_packet_t;

    // Read port 0 carries rj, read port 1 carries rk or rd
    typedef struct packed {
        logic                             valid;
        aluop_e                           aluop;
        alusel_e                          alusel;
        logic [1:0]                       reg_read_valid;
        logic [1:0][`REG_ADDR_W-1:0]      reg_read_addr;
        logic                             reg_write_valid;
        logic [`REG_ADDR_W-1:0]           reg_write_addr;
        logic [`XLEN-1:0]                 imm;
        logic                             use_imm;
        logic                             is_csr;
        logic                             is_kernel;
        logic                             is_break;
        logic                             is_syscall;
        logic                             mem_load;
        logic                             mem_store;
    } decode_result_t;

    typedef struct packed {
        logic [`XLEN-1:0]                 pc;
        logic [`XLEN-1:0]                 instr;
        logic                             decode_valid;
        aluop_e                           aluop;
        alusel_e                          alusel;
        logic [1:0]                       reg_read_valid;
        logic [1:0][`REG_ADDR_W-1:0]      reg_read_addr;
        logic                             reg_write_valid;
        logic [`REG_ADDR_W-1:0]           reg_write_addr;
        logic [`XLEN-1:0]                 imm;
        logic                             use_imm;
        logic                             is_csr;
        logic                             mem_load;
        logic                             mem_store;
        logic                             excp;
        logic [`EXCP_NUM_W-1:0]           excp_num;
    } dispatch_packet_t;

endpackage

`default_nettype wire

//--- logic/decoder_3r.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module decoder_3r
    import core_types_pkg::*;
(
    input  wire logic [`XLEN-1:0] instr_i,
    output decode_result_t        result_o
);

    logic [16:0]            opcode;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rj;
    logic [`REG_ADDR_W-1:0] rk;

    assign opcode = instr_i[31:15];
    assign rd     = instr_i[4:0];
    assign rj     = instr_i[9:5];
    assign rk     = instr_i[14:10];

    always_comb begin
        result_o = '0;
        case (opcode)
            `OP3R_ADDW: begin
                result_o.aluop  = OP_ADD;
                result_o.alusel = SEL_ARITH;
            end
            `OP3R_SUBW: begin
                result_o.aluop  = OP_SUB;
                result_o.alusel = SEL_ARITH;
            end
            `OP3R_AND: begin
                result_o.aluop  = OP_AND;
                result_o.alusel = SEL_LOGIC;
            end
            `OP3R_OR: begin
                result_o.aluop  = OP_OR;
                result_o.alusel = SEL_LOGIC;
            end
            // Traps carry no operands, only the flag
            `OP3R_BREAK:   result_o.is_break   = 1'b1;
            `OP3R_SYSCALL: result_o.is_syscall = 1'b1;
            default: ;
        endcase

        // ALU forms read rj, rk and write rd
        if (result_o.aluop != OP_NOP) begin
            result_o.reg_read_valid   = 2'b11;
            result_o.reg_read_addr[0] = rj;
            result_o.reg_read_addr[1] = rk;
            result_o.reg_write_valid  = 1'b1;
            result_o.reg_write_addr   = rd;
        end

        result_o.valid = (result_o.aluop != OP_NOP) | result_o.is_break | result_o.is_syscall;
    end

endmodule

`default_nettype wire

//--- logic/decoder_2ri12.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module decoder_2ri12
    import core_types_pkg::*;
(
    input  wire logic [`XLEN-1:0] instr_i,
    output decode_result_t        result_o
);

    logic [9:0]       opcode;
    logic [`XLEN-1:0] simm12;

    assign opcode = instr_i[31:22];
    assign simm12 = {{(`XLEN-12){instr_i[21]}}, instr_i[21:10]};

    always_comb begin
        result_o = '0;
        case (opcode)
            `OP12_ADDIW: begin
                result_o.aluop           = OP_ADD;
                result_o.alusel          = SEL_ARITH;
                result_o.reg_write_valid = 1'b1;
            end
            `OP12_LDW: begin
                result_o.aluop           = OP_LD_W;
                result_o.alusel          = SEL_MEM;
                result_o.reg_write_valid = 1'b1;
                result_o.mem_load        = 1'b1;
            end
            `OP12_STW: begin
                result_o.aluop             = OP_ST_W;
                result_o.alusel            = SEL_MEM;
                // Store data comes from rd
                result_o.reg_read_valid[1] = 1'b1;
                result_o.reg_read_addr[1]  = instr_i[4:0];
                result_o.mem_store         = 1'b1;
            end
            default: ;
        endcase

        if (result_o.aluop != OP_NOP) begin
            result_o.valid             = 1'b1;
            result_o.reg_read_valid[0] = 1'b1;
            result_o.reg_read_addr[0]  = instr_i[9:5];
            result_o.imm               = simm12;
            result_o.use_imm           = 1'b1;
            if (result_o.reg_write_valid) begin
                result_o.reg_write_addr = instr_i[4:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder_1ri20.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module decoder_1ri20
    import core_types_pkg::*;
(
    input  wire logic [`XLEN-1:0] instr_i,
    output decode_result_t        result_o
);

    logic [6:0] opcode;

    assign opcode = instr_i[31:25];

    always_comb begin
        result_o = '0;
        case (opcode)
            `OP20_LU12IW: begin
                result_o.aluop  = OP_LUI;
                result_o.alusel = SEL_MOVE;
            end
            `OP20_PCADDU12I: begin
                result_o.aluop  = OP_PCADDU12I;
                result_o.alusel = SEL_ARITH;
            end
            default: ;
        endcase

        if (result_o.aluop != OP_NOP) begin
            result_o.valid           = 1'b1;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = instr_i[4:0];
            // Upper 20 bits, low 12 cleared
            result_o.imm             = {instr_i[24:5], 12'b0};
            result_o.use_imm         = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder_i26.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module decoder_i26
    import core_types_pkg::*;
(
    input  wire logic [`XLEN-1:0] instr_i,
    output decode_result_t        result_o
);

    logic [5:0]  opcode;
    logic [25:0] offs26;

    assign opcode = instr_i[31:26];
    // High half of the offset sits in the low instruction bits
    assign offs26 = {instr_i[9:0], instr_i[25:10]};

    always_comb begin
        result_o = '0;
        if (opcode == `OP26_B || opcode == `OP26_BL) begin
            result_o.valid   = 1'b1;
            result_o.aluop   = (opcode == `OP26_BL) ? OP_BL : OP_B;
            result_o.alusel  = SEL_BRANCH;
            result_o.imm     = {{(`XLEN-28){offs26[25]}}, offs26, 2'b00};
            result_o.use_imm = 1'b1;
            // Link register is r1
            if (opcode == `OP26_BL) begin
                result_o.reg_write_valid = 1'b1;
                result_o.reg_write_addr  = `REG_ADDR_W'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder_csr.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module decoder_csr
    import core_types_pkg::*;
(
    input  wire logic [`XLEN-1:0] instr_i,
    output decode_result_t        result_o
);

    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rj;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];

    always_comb begin
        result_o = '0;
        if (instr_i[31:24] == `OPCSR) begin
            result_o.valid           = 1'b1;
            result_o.alusel          = SEL_CSR;
            result_o.reg_write_valid = 1'b1;
            result_o.reg_write_addr  = rd;
            // CSR number, zero-extended
            result_o.imm             = {{(`XLEN-14){1'b0}}, instr_i[23:10]};
            result_o.use_imm         = 1'b1;
            result_o.is_csr          = 1'b1;
            result_o.is_kernel       = 1'b1;

            // rj picks the variant; csrxchg uses rj as the write mask
            if (rj == `REG_ADDR_W'd0) begin
                result_o.aluop = OP_CSRRD;
            end else if (rj == `REG_ADDR_W'd1) begin
                result_o.aluop             = OP_CSRWR;
                result_o.reg_read_valid[1] = 1'b1;
                result_o.reg_read_addr[1]  = rd;
            end else begin
                result_o.aluop            = OP_CSRXCHG;
                result_o.reg_read_valid   = 2'b11;
                result_o.reg_read_addr[0] = rj;
                result_o.reg_read_addr[1] = rd;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/id_dispatch_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_dispatch_reg
    import core_types_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire logic              in_valid_i,
    output logic                   in_ready_o,
    input  wire dispatch_packet_t  in_packet_i,
    output logic                   out_valid_o,
    input  wire logic              out_ready_i,
    output dispatch_packet_t       out_packet_o
);

    logic             valid_q;
    dispatch_packet_t packet_q;

    // Room when empty or when the held entry leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            packet_q <= in_packet_i;
        end
    end

    assign out_valid_o  = valid_q;
    assign out_packet_o = packet_q;

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module id_stage
    import core_types_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_i,
    input  wire fetch_packet_t     fetch_i,
    input  wire logic              fetch_valid_i,
    output logic                   fetch_ready_o,
    input  wire logic              has_int_i,
    input  wire logic [1:0]        csr_plv_i,
    output dispatch_packet_t       dispatch_o,
    output logic                   dispatch_valid_o,
    input  wire logic              dispatch_ready_i
);

    localparam int NUM_DECODERS = 5;

    decode_result_t         sub_result [NUM_DECODERS];
    decode_result_t         merged;
    logic                   excp_ine;
    logic                   excp_ipe;
    logic [`FE_EXCP_W-1:0]  fe_code;
    logic [`EXCP_NUM_W-1:0] excp_num;
    dispatch_packet_t       packet;

    // Format decoders, each silent unless the word is one of its own
    decoder_3r u_decoder_3r (
        .instr_i  (fetch_i.instr),
        .result_o (sub_result[0])
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i  (fetch_i.instr),
        .result_o (sub_result[1])
    );

    decoder_1ri20 u_decoder_1ri20 (
        .instr_i  (fetch_i.instr),
        .result_o (sub_result[2])
    );

    decoder_i26 u_decoder_i26 (
        .instr_i  (fetch_i.instr),
        .result_o (sub_result[3])
    );

    decoder_csr u_decoder_csr (
        .instr_i  (fetch_i.instr),
        .result_o (sub_result[4])
    );

    // At most one decoder matches, so OR is a mux
    always_comb begin : merge_comb
        merged = '0;
        for (int i = 0; i < NUM_DECODERS; i++) begin
            merged = decode_result_t'(merged | sub_result[i]);
        end
    end

    assign excp_ine = ~merged.valid;
    assign excp_ipe = merged.is_kernel & (csr_plv_i == `PLV_USER);

    // Front-end code only counts when its flag is set
    assign fe_code  = fetch_i.excp ? fetch_i.excp_code : '0;
    assign excp_num = {excp_ipe, excp_ine, merged.is_break, merged.is_syscall,
                       fe_code, has_int_i};

    always_comb begin : packet_comb
        packet                 = '0;
        packet.pc              = fetch_i.pc;
        packet.instr           = fetch_i.instr;
        packet.decode_valid    = merged.valid;
        packet.aluop           = merged.aluop;
        packet.alusel          = merged.alusel;
        packet.reg_read_valid  = merged.reg_read_valid;
        packet.reg_read_addr   = merged.reg_read_addr;
        packet.reg_write_valid = merged.reg_write_valid;
        packet.reg_write_addr  = merged.reg_write_addr;
        packet.imm             = merged.imm;
        packet.use_imm         = merged.use_imm;
        packet.is_csr          = merged.is_csr;
        packet.mem_load        = merged.mem_load;
        packet.mem_store       = merged.mem_store;
        packet.excp            = |excp_num;
        packet.excp_num        = excp_num;
    end

    id_dispatch_reg u_dispatch_reg (
        .clk          (clk),
        .rst_i        (rst_i),
        .in_valid_i   (fetch_valid_i),
        .in_ready_o   (fetch_ready_o),
        .in_packet_i  (packet),
        .out_valid_o  (dispatch_valid_o),
        .out_ready_i  (dispatch_ready_i),
        .out_packet_o (dispatch_o)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb/id_stage_props.sv
`timescale 1ns/100ps
`default_nettype none

module id_stage_props
    import core_types_pkg::*;
(
    input wire logic             clk,
    input wire logic             rst_i,
    input wire logic             dispatch_valid_o,
    input wire logic             dispatch_ready_i,
    input wire dispatch_packet_t dispatch_o
);

    // Register comes out of reset empty
    valid_low_after_reset: assert property (@(posedge clk) rst_i |=> !dispatch_valid_o)
        else $error("dispatch_valid_o high right after reset");

    // Held entry may not change under back-pressure
    hold_under_stall: assert property (@(posedge clk) disable iff (rst_i)
        dispatch_valid_o && !dispatch_ready_i |=> dispatch_valid_o && $stable(dispatch_o))
        else $error("dispatch output changed while stalled");

    excp_is_or_of_vector: assert property (@(posedge clk) disable iff (rst_i)
        dispatch_valid_o |-> dispatch_o.excp == (|dispatch_o.excp_num))
        else $error("excp does not match the OR of excp_num");

endmodule

`default_nettype wire

//--- tb/tb_id_stage.sv
`include "id_macros.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_id_stage
    import core_types_pkg::*;
();

    localparam int NUM_DIRECTED   = 17;
    localparam int NUM_RANDOM     = 60;
    localparam int TOTAL_ITEMS    = 2 * NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_ITEMS;

    logic             clk;
    logic             rst;
    fetch_packet_t    fetch_i;
    logic             fetch_valid_i;
    logic             fetch_ready_o;
    logic             has_int_i;
    logic [1:0]       csr_plv_i;
    dispatch_packet_t dispatch_o;
    logic             dispatch_valid_o;
    logic             dispatch_ready_i;

    integer           seed;
    int               errors;
    int               checked;
    int               cycles;
    int               idx;
    logic [31:0]      r;
    logic [31:0]      word;
    logic [31:0]      directed [NUM_DIRECTED];
    dispatch_packet_t exp_q [$];
    dispatch_packet_t exp_pkt;
    // Model of the dispatch register occupancy
    logic             held;
    logic             want_ready;

    tb_clock_gen #(.RESET_CYCLES(5)) u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    id_stage DUT (
        .clk              (clk),
        .rst_i            (rst),
        .fetch_i          (fetch_i),
        .fetch_valid_i    (fetch_valid_i),
        .fetch_ready_o    (fetch_ready_o),
        .has_int_i        (has_int_i),
        .csr_plv_i        (csr_plv_i),
        .dispatch_o       (dispatch_o),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_ready_i (dispatch_ready_i)
    );

    bind id_stage id_stage_props u_props (
        .clk              (clk),
        .rst_i            (rst_i),
        .dispatch_valid_o (dispatch_valid_o),
        .dispatch_ready_i (dispatch_ready_i),
        .dispatch_o       (dispatch_o)
    );

    // Reference decode written from the ISA encoding rules
    function automatic dispatch_packet_t expect_packet(fetch_packet_t f, logic intr,
                                                       logic [1:0] plv);
        dispatch_packet_t p;
        logic [31:0]      w;
        logic [16:0]      op17;
        logic [4:0]       rd;
        logic [4:0]       rj;
        logic [4:0]       rk;
        logic             kern;
        logic             brk;
        logic             sys;
        p    = '0;
        w    = f.instr;
        op17 = w[31:15];
        rd   = w[4:0];
        rj   = w[9:5];
        rk   = w[14:10];
        kern = 1'b0;
        brk  = 1'b0;
        sys  = 1'b0;
        p.pc           = f.pc;
        p.instr        = w;
        p.decode_valid = 1'b1;
        if (op17 inside {`OP3R_ADDW, `OP3R_SUBW, `OP3R_AND, `OP3R_OR}) begin
            p.aluop = (op17 == `OP3R_ADDW) ? OP_ADD :
                      (op17 == `OP3R_SUBW) ? OP_SUB :
                      (op17 == `OP3R_AND)  ? OP_AND : OP_OR;
            p.alusel = (op17 == `OP3R_ADDW || op17 == `OP3R_SUBW) ? SEL_ARITH : SEL_LOGIC;
            p.reg_read_valid  = 2'b11;
            p.reg_read_addr   = {rk, rj};
            p.reg_write_valid = 1'b1;
            p.reg_write_addr  = rd;
        end else if (op17 == `OP3R_BREAK) begin
            brk = 1'b1;
        end else if (op17 == `OP3R_SYSCALL) begin
            sys = 1'b1;
        end else if (w[31:22] inside {`OP12_ADDIW, `OP12_LDW, `OP12_STW}) begin
            p.reg_read_valid[0] = 1'b1;
            p.reg_read_addr[0]  = rj;
            p.imm               = {{20{w[21]}}, w[21:10]};
            p.use_imm           = 1'b1;
            p.alusel            = SEL_MEM;
            if (w[31:22] == `OP12_STW) begin
                p.aluop             = OP_ST_W;
                p.reg_read_valid[1] = 1'b1;
                p.reg_read_addr[1]  = rd;
                p.mem_store         = 1'b1;
            end else begin
                p.reg_write_valid = 1'b1;
                p.reg_write_addr  = rd;
                p.aluop           = (w[31:22] == `OP12_ADDIW) ? OP_ADD : OP_LD_W;
                p.alusel          = (w[31:22] == `OP12_ADDIW) ? SEL_ARITH : SEL_MEM;
                p.mem_load        = (w[31:22] == `OP12_LDW);
            end
        end else if (w[31:25] inside {`OP20_LU12IW, `OP20_PCADDU12I}) begin
            p.aluop           = (w[31:25] == `OP20_LU12IW) ? OP_LUI : OP_PCADDU12I;
            p.alusel          = (w[31:25] == `OP20_LU12IW) ? SEL_MOVE : SEL_ARITH;
            p.reg_write_valid = 1'b1;
            p.reg_write_addr  = rd;
            p.imm             = {w[24:5], 12'b0};
            p.use_imm         = 1'b1;
        end else if (w[31:26] inside {`OP26_B, `OP26_BL}) begin
            p.aluop           = (w[31:26] == `OP26_BL) ? OP_BL : OP_B;
            p.alusel          = SEL_BRANCH;
            p.imm             = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
            p.use_imm         = 1'b1;
            p.reg_write_valid = (w[31:26] == `OP26_BL);
            p.reg_write_addr  = (w[31:26] == `OP26_BL) ? 5'd1 : 5'd0;
        end else if (w[31:24] == `OPCSR) begin
            kern              = 1'b1;
            p.is_csr          = 1'b1;
            p.alusel          = SEL_CSR;
            p.reg_write_valid = 1'b1;
            p.reg_write_addr  = rd;
            p.imm             = {18'b0, w[23:10]};
            p.use_imm         = 1'b1;
            p.aluop = (rj == 5'd0) ? OP_CSRRD : (rj == 5'd1) ? OP_CSRWR : OP_CSRXCHG;
            p.reg_read_valid  = (rj == 5'd0) ? 2'b00 : (rj == 5'd1) ? 2'b10 : 2'b11;
            p.reg_read_addr   = (rj == 5'd0) ? 10'd0 : (rj == 5'd1) ? {rd, 5'd0} : {rd, rj};
        end else begin
            p.decode_valid = 1'b0;
        end
        // Front-end code is masked by its flag
        p.excp_num = {kern && plv == `PLV_USER, ~p.decode_valid, brk, sys,
                      f.excp ? f.excp_code : 4'b0, intr};
        p.excp     = |p.excp_num;
        return p;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        assert (got === want) else begin
            $display("FAIL dispatch_o.%s: got 0x%0h, expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_packet(input dispatch_packet_t want);
        compare_field("pc", dispatch_o.pc, want.pc);
        compare_field("instr", dispatch_o.instr, want.instr);
        compare_field("decode_valid", 32'(dispatch_o.decode_valid), 32'(want.decode_valid));
        compare_field("aluop", 32'(dispatch_o.aluop), 32'(want.aluop));
        compare_field("alusel", 32'(dispatch_o.alusel), 32'(want.alusel));
        compare_field("reg_read_valid", 32'(dispatch_o.reg_read_valid),
                      32'(want.reg_read_valid));
        compare_field("reg_read_addr", 32'(dispatch_o.reg_read_addr), 32'(want.reg_read_addr));
        compare_field("reg_write_valid", 32'(dispatch_o.reg_write_valid),
                      32'(want.reg_write_valid));
        compare_field("reg_write_addr", 32'(dispatch_o.reg_write_addr),
                      32'(want.reg_write_addr));
        compare_field("imm", dispatch_o.imm, want.imm);
        compare_field("use_imm", 32'(dispatch_o.use_imm), 32'(want.use_imm));
        compare_field("is_csr", 32'(dispatch_o.is_csr), 32'(want.is_csr));
        compare_field("mem_load", 32'(dispatch_o.mem_load), 32'(want.mem_load));
        compare_field("mem_store", 32'(dispatch_o.mem_store), 32'(want.mem_store));
        compare_field("excp", 32'(dispatch_o.excp), 32'(want.excp));
        compare_field("excp_num", 32'(dispatch_o.excp_num), 32'(want.excp_num));
    endtask

    // Entered 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_instr(input logic [31:0] instr, input logic [1:0] plv);
        logic [31:0] rv;
        logic        accepted;
        rv                = $random(seed);
        fetch_i.pc        = $random(seed);
        fetch_i.instr     = instr;
        fetch_i.excp      = rv[0];
        fetch_i.excp_code = rv[4:1];
        has_int_i         = rv[5];
        csr_plv_i         = plv;
        fetch_valid_i     = 1'b1;
        accepted          = 1'b0;
        while (!accepted) begin
            rv               = $random(seed);
            dispatch_ready_i = rv[0];
            @(negedge clk);
            if (fetch_ready_o) begin
                accepted = 1'b1;
                exp_q.push_back(expect_packet(fetch_i, has_int_i, csr_plv_i));
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Output scoreboard and handshake model, sampled mid-cycle
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            held = 1'b0;
        end else begin
            want_ready = !held || dispatch_ready_i;
            assert (dispatch_valid_o === held) else begin
                $display("FAIL dispatch_valid_o: got 0x%0h, expected 0x%0h",
                         dispatch_valid_o, held);
                errors++;
            end
            assert (fetch_ready_o === want_ready) else begin
                $display("FAIL fetch_ready_o: got 0x%0h, expected 0x%0h", fetch_ready_o,
                         want_ready);
                errors++;
            end
            if (dispatch_valid_o && dispatch_ready_i) begin
                assert (exp_q.size() > 0) else begin
                    $display("Output transfer with no accepted instruction pending");
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_pkt = exp_q.pop_front();
                    check_packet(exp_pkt);
                    checked++;
                end
            end
            // Filled by an accepted input, kept while the output stalls
            held = (fetch_valid_i && want_ready) || (held && !dispatch_ready_i);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d packets still expected", cycles,
                     exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed             = 32'h85b;
        errors           = 0;
        checked          = 0;
        cycles           = 0;
        fetch_i          = '0;
        fetch_valid_i    = 1'b0;
        has_int_i        = 1'b0;
        csr_plv_i        = 2'd0;
        dispatch_ready_i = 1'b0;

        directed[0]  = {`OP3R_ADDW, 5'd3, 5'd2, 5'd1};
        directed[1]  = {`OP3R_SUBW, 5'd31, 5'd17, 5'd9};
        directed[2]  = {`OP3R_AND, 5'd4, 5'd5, 5'd6};
        directed[3]  = {`OP3R_OR, 5'd10, 5'd0, 5'd30};
        directed[4]  = {`OP3R_BREAK, 15'h0005};
        directed[5]  = {`OP3R_SYSCALL, 15'h0011};
        directed[6]  = {`OP12_ADDIW, 12'h800, 5'd7, 5'd8};
        directed[7]  = {`OP12_LDW, 12'h07c, 5'd3, 5'd4};
        directed[8]  = {`OP12_STW, 12'hff0, 5'd2, 5'd12};
        directed[9]  = {`OP20_LU12IW, 20'habcde, 5'd5};
        directed[10] = {`OP20_PCADDU12I, 20'h80001, 5'd13};
        // Offset high bits live in instr[9:0]
        directed[11] = {`OP26_B, 16'hfff0, 10'h3ff};
        directed[12] = {`OP26_BL, 16'h2345, 10'h001};
        directed[13] = {`OPCSR, 14'h0005, 5'd0, 5'd4};
        directed[14] = {`OPCSR, 14'h0030, 5'd1, 5'd6};
        directed[15] = {`OPCSR, 14'h3fff, 5'd9, 5'd10};
        directed[16] = 32'hffff_ffff;

        @(negedge rst);
        @(posedge clk);
        #1;
        // Kernel level first, then user level for the IPE cases
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < NUM_DIRECTED; i++) begin
                send_instr(directed[i], (pass == 0) ? 2'd0 : `PLV_USER);
            end
        end
        // Random words, half of them keeping a known opcode
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r   = $random(seed);
            idx = int'(r[20:16]) % NUM_DIRECTED;
            if (r[31]) begin
                word = $random(seed);
            end else begin
                word = {directed[idx][31:15], r[14:0]};
            end
            send_instr(word, r[30:29]);
        end
        fetch_valid_i = 1'b0;

        while (exp_q.size() != 0) begin
            r                = $random(seed);
            dispatch_ready_i = r[0];
            @(posedge clk);
            #1;
        end

        assert (checked == TOTAL_ITEMS) else begin
            $display("Only %0d of %0d instructions reached the output", checked, TOTAL_ITEMS);
            errors++;
        end
        $display("Checked %0d packets, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
logic/core_types_pkg.sv
logic/decoder_3r.sv
logic/decoder_2ri12.sv
logic/decoder_1ri20.sv
logic/decoder_i26.sv
logic/decoder_csr.sv
logic/id_dispatch_reg.sv
logic/id_stage.sv
tb/tb_clock_gen.sv
tb/id_stage_props.sv
tb/tb_id_stage.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_id_stage
FILELIST = verilog.f
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
